// File: logic/wb_bank_bridge.sv
`timescale 1ns/1ps

module wb_bank_bridge (
   input  logic                            wbm_clk_i,
   input  logic                            wbm_rst_n,
   wb_req_if.bridge_dst                    req,
   input  logic [wb_host_pkg::BANK_W-1:0]  bank_sel_i,
   input  logic [wb_host_pkg::WB_DW-1:0]   wbs_dat_i,
   input  logic                            wbs_ack_i,
   input  logic                            wbs_err_i,
   output logic                            wbs_cyc_o,
   output logic                            wbs_stb_o,
   output logic [wb_host_pkg::WB_AW-1:0]   wbs_adr_o,
   output logic                            wbs_we_o,
   output logic [wb_host_pkg::WB_DW-1:0]   wbs_dat_o,
   output logic [wb_host_pkg::WB_SW-1:0]   wbs_sel_o,
   output logic [wb_host_pkg::WB_DW-1:0]   br_rdata_o,
   output logic                            br_ack_o,
   output logic                            br_err_o
);
   import wb_host_pkg::*;

   bridge_state_e     state;
   logic              start;      // launch a slave cycle
   logic              done;       // slave answered
   logic [WB_AW-1:0]  remote_adr;

   // bank select 15:2 on top of the low 18 address bits
   assign remote_adr = {bank_sel_i[BANK_W-1:2], req.adr[LOW_ADR_W-1:0]};

   // skip the cycle where our own response is still on its way back
   assign start = (state == BR_IDLE) && req.req_remote && !br_ack_o && !br_err_o;
   assign done  = (state == BR_BUSY) && (wbs_ack_i || wbs_err_i);

   // ------------------------------
   // slave side FSM
   // ------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         state      <= BR_IDLE;
         wbs_cyc_o  <= 1'b0;
         wbs_stb_o  <= 1'b0;
         wbs_we_o   <= 1'b0;
         br_ack_o   <= 1'b0;
         br_err_o   <= 1'b0;
         br_rdata_o <= '0;
      end
      else
      begin
         br_ack_o <= 1'b0;  // pulses by default
         br_err_o <= 1'b0;
         if (start)
         begin
            state     <= BR_BUSY;
            wbs_cyc_o <= 1'b1;
            wbs_stb_o <= 1'b1;
            wbs_we_o  <= req.we;
         end
         else if (done)
         begin
            state      <= BR_IDLE;
            wbs_cyc_o  <= 1'b0;
            wbs_stb_o  <= 1'b0;
            wbs_we_o   <= 1'b0;
            br_ack_o   <= wbs_ack_i && !wbs_err_i;  // err wins if both
            br_err_o   <= wbs_err_i;
            br_rdata_o <= wbs_dat_i;
         end
      end
   end

   // payload outputs, only meaningful while cyc is high
   always_ff @(posedge wbm_clk_i)
   begin
      if (start)
      begin
         wbs_adr_o <= remote_adr;
         wbs_dat_o <= req.wdat;
         wbs_sel_o <= req.sel;
      end
   end

endmodule

// File: logic/wb_host.sv
`timescale 1ns/1ps

module wb_host #(
   parameter logic [wb_host_pkg::BANK_W-1:0] BANK_SEL_RST = 16'h1000  // bank select reset
) (
   input  logic                            wbm_clk_i,
   input  logic                            wbm_rst_n,
   // ------------------------------
   // master port
   // ------------------------------
   input  logic                            wbm_cyc_i,
   input  logic                            wbm_stb_i,
   input  logic                            wbm_we_i,
   input  logic [wb_host_pkg::WB_AW-1:0]   wbm_adr_i,
   input  logic [wb_host_pkg::WB_DW-1:0]   wbm_dat_i,
   input  logic [wb_host_pkg::WB_SW-1:0]   wbm_sel_i,
   output logic [wb_host_pkg::WB_DW-1:0]   wbm_dat_o,
   output logic                            wbm_ack_o,
   output logic                            wbm_err_o,
   // ------------------------------
   // remote slave port
   // ------------------------------
   input  logic [wb_host_pkg::WB_DW-1:0]   wbs_dat_i,
   input  logic                            wbs_ack_i,
   input  logic                            wbs_err_i,
   output logic                            wbs_cyc_o,
   output logic                            wbs_stb_o,
   output logic [wb_host_pkg::WB_AW-1:0]   wbs_adr_o,
   output logic                            wbs_we_o,
   output logic [wb_host_pkg::WB_DW-1:0]   wbs_dat_o,
   output logic [wb_host_pkg::WB_SW-1:0]   wbs_sel_o,
   // reset and clock controls
   output logic                            wbd_int_rst_n_o,
   output logic                            bist_rst_n_o,
   output logic                            mac_rst_n_o,
   output logic [wb_host_pkg::WB_DW-1:0]   cfg_clk_ctrl1_o,
   output logic [wb_host_pkg::WB_DW-1:0]   cfg_clk_ctrl2_o
);
   import wb_host_pkg::*;

   logic [WB_DW-1:0]   reg_rdata;  // local bank response
   logic               reg_ack;
   logic [WB_DW-1:0]   br_rdata;   // remote response
   logic               br_ack;
   logic               br_err;
   logic [BANK_W-1:0]  bank_sel;

   wb_req_if u_req_if ();  // registered request

   wb_req_stage u_req_stage (
      .wbm_clk_i   (wbm_clk_i),
      .wbm_rst_n   (wbm_rst_n),
      .wbm_cyc_i   (wbm_cyc_i),
      .wbm_stb_i   (wbm_stb_i),
      .wbm_we_i    (wbm_we_i),
      .wbm_adr_i   (wbm_adr_i),
      .wbm_dat_i   (wbm_dat_i),
      .wbm_sel_i   (wbm_sel_i),
      .reg_rdata_i (reg_rdata),
      .reg_ack_i   (reg_ack),
      .br_rdata_i  (br_rdata),
      .br_ack_i    (br_ack),
      .br_err_i    (br_err),
      .wbm_dat_o   (wbm_dat_o),
      .wbm_ack_o   (wbm_ack_o),
      .wbm_err_o   (wbm_err_o),
      .req         (u_req_if)
   );

   wb_host_regs #(
      .BANK_SEL_RST (BANK_SEL_RST)
   ) u_host_regs (
      .wbm_clk_i       (wbm_clk_i),
      .wbm_rst_n       (wbm_rst_n),
      .req             (u_req_if),
      .reg_rdata_o     (reg_rdata),
      .reg_ack_o       (reg_ack),
      .bank_sel_o      (bank_sel),
      .wbd_int_rst_n_o (wbd_int_rst_n_o),
      .bist_rst_n_o    (bist_rst_n_o),
      .mac_rst_n_o     (mac_rst_n_o),
      .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o),
      .cfg_clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

   // slave side runs on the master clock
   wb_bank_bridge u_bank_bridge (
      .wbm_clk_i  (wbm_clk_i),
      .wbm_rst_n  (wbm_rst_n),
      .req        (u_req_if),
      .bank_sel_i (bank_sel),
      .wbs_dat_i  (wbs_dat_i),
      .wbs_ack_i  (wbs_ack_i),
      .wbs_err_i  (wbs_err_i),
      .wbs_cyc_o  (wbs_cyc_o),
      .wbs_stb_o  (wbs_stb_o),
      .wbs_adr_o  (wbs_adr_o),
      .wbs_we_o   (wbs_we_o),
      .wbs_dat_o  (wbs_dat_o),
      .wbs_sel_o  (wbs_sel_o),
      .br_rdata_o (br_rdata),
      .br_ack_o   (br_ack),
      .br_err_o   (br_err)
   );

endmodule

// File: logic/wb_host_pkg.sv
package wb_host_pkg;

   // ------------------------------
   // bus widths
   // ------------------------------
   localparam int unsigned WB_AW     = 32;  // wishbone address
   localparam int unsigned WB_DW     = 32;  // wishbone data
   localparam int unsigned WB_SW     = 4;   // byte selects
   localparam int unsigned REG_IDX_W = 2;   // local register index, adr 3:2
   localparam int unsigned BANK_W    = 16;  // bank select register width
   localparam int unsigned LOW_ADR_W = 18;  // adr bits passed straight to the slave

   // region field, adr 19:18
   typedef enum logic [1:0] {
      REGION_REMOTE0 = 2'b00,  // remote slave, lower half
      REGION_REMOTE1 = 2'b01,  // remote slave, upper half
      REGION_LOCAL   = 2'b10,  // control register bank
      REGION_NONE    = 2'b11   // unmapped, error response
   } wb_region_e;

   // remote bridge, single outstanding access
   typedef enum logic {
      BR_IDLE = 1'b0,
      BR_BUSY = 1'b1
   } bridge_state_e;

   // local register map
   typedef enum logic [REG_IDX_W-1:0] {
      REG_GLB_CTRL  = 2'd0,  // reset controls in bits 2:0
      REG_BANK_SEL  = 2'd1,  // upper remote address bits
      REG_CLK_CTRL1 = 2'd2,
      REG_CLK_CTRL2 = 2'd3
   } reg_idx_e;

endpackage

// File: logic/wb_host_regs.sv
`timescale 1ns/1ps

module wb_host_regs #(
   parameter logic [wb_host_pkg::BANK_W-1:0] BANK_SEL_RST = 16'h1000
) (
   input  logic                             wbm_clk_i,
   input  logic                             wbm_rst_n,
   wb_req_if.reg_dst                        req,
   output logic [wb_host_pkg::WB_DW-1:0]    reg_rdata_o,
   output logic                             reg_ack_o,
   output logic [wb_host_pkg::BANK_W-1:0]   bank_sel_o,
   output logic                             wbd_int_rst_n_o,
   output logic                             bist_rst_n_o,
   output logic                             mac_rst_n_o,
   output logic [wb_host_pkg::WB_DW-1:0]    cfg_clk_ctrl1_o,
   output logic [wb_host_pkg::WB_DW-1:0]    cfg_clk_ctrl2_o
);
   import wb_host_pkg::*;

   logic [WB_DW-1:0]  glb_ctrl;  // global control
   logic [WB_DW-1:0]  rd_mux;
   logic              wr_en;
   logic              rd_en;

   // first cycle of a local request only
   assign wr_en = req.req_local && req.we && !reg_ack_o;
   assign rd_en = req.req_local && !req.we && !reg_ack_o;

   // ------------------------------
   // register writes
   // ------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_ctrl        <= '0;            // all resets asserted
         bank_sel_o      <= BANK_SEL_RST;
         cfg_clk_ctrl1_o <= '0;
         cfg_clk_ctrl2_o <= '0;
      end
      else if (wr_en)
      begin
         case (req.reg_idx)
            REG_GLB_CTRL:
            begin
               for (int b = 0; b < WB_SW; b++)
               begin
                  if (req.sel[b])
                     glb_ctrl[8*b +: 8] <= req.wdat[8*b +: 8];  // per byte lane
               end
            end
            REG_BANK_SEL:  bank_sel_o      <= req.wdat[BANK_W-1:0];  // sel ignored
            REG_CLK_CTRL1: cfg_clk_ctrl1_o <= req.wdat;
            REG_CLK_CTRL2: cfg_clk_ctrl2_o <= req.wdat;
            default:       glb_ctrl        <= glb_ctrl;
         endcase
      end
   end

   // ------------------------------
   // read mux and ack
   // ------------------------------
   always_comb
   begin
      case (req.reg_idx)
         REG_GLB_CTRL:  rd_mux = glb_ctrl;
         REG_BANK_SEL:  rd_mux = {{(WB_DW-BANK_W){1'b0}}, bank_sel_o};  // upper half zero
         REG_CLK_CTRL1: rd_mux = cfg_clk_ctrl1_o;
         REG_CLK_CTRL2: rd_mux = cfg_clk_ctrl2_o;
         default:       rd_mux = '0;
      endcase
   end

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         reg_ack_o   <= 1'b0;
         reg_rdata_o <= '0;
      end
      else
      begin
         reg_ack_o <= req.req_local && !reg_ack_o;  // one pulse, no re-raise
         if (rd_en)
            reg_rdata_o <= rd_mux;
      end
   end

   // reset controls straight from global control
   assign wbd_int_rst_n_o = glb_ctrl[0];
   assign bist_rst_n_o    = glb_ctrl[1];
   assign mac_rst_n_o     = glb_ctrl[2];

endmodule

// File: logic/wb_req_if.sv
`timescale 1ns/1ps

interface wb_req_if;
   import wb_host_pkg::*;

   logic              req_local;   // level, local access pending
   logic              req_remote;  // level, remote access pending
   logic [WB_AW-1:0]  adr;         // registered master address
   logic              we;
   logic [WB_DW-1:0]  wdat;
   logic [WB_SW-1:0]  sel;
   reg_idx_e          reg_idx;     // from adr 3:2

   // request stage drives everything
   modport req_src (
      output req_local, req_remote, adr, we, wdat, sel, reg_idx
   );

   // register bank only sees local accesses
   modport reg_dst (
      input req_local, we, wdat, sel, reg_idx
   );

   // bridge only sees remote accesses
   modport bridge_dst (
      input req_remote, adr, we, wdat, sel
   );

endinterface

// File: logic/wb_req_stage.sv
`timescale 1ns/1ps

module wb_req_stage (
   input  logic                            wbm_clk_i,
   input  logic                            wbm_rst_n,
   input  logic                            wbm_cyc_i,
   input  logic                            wbm_stb_i,
   input  logic                            wbm_we_i,
   input  logic [wb_host_pkg::WB_AW-1:0]   wbm_adr_i,
   input  logic [wb_host_pkg::WB_DW-1:0]   wbm_dat_i,
   input  logic [wb_host_pkg::WB_SW-1:0]   wbm_sel_i,
   input  logic [wb_host_pkg::WB_DW-1:0]   reg_rdata_i,  // local bank read data
   input  logic                            reg_ack_i,
   input  logic [wb_host_pkg::WB_DW-1:0]   br_rdata_i,   // remote read data
   input  logic                            br_ack_i,
   input  logic                            br_err_i,
   output logic [wb_host_pkg::WB_DW-1:0]   wbm_dat_o,
   output logic                            wbm_ack_o,
   output logic                            wbm_err_o,
   wb_req_if.req_src                       req
);
   import wb_host_pkg::*;

   logic              stb_q;      // stb qualified with cyc
   logic              req_nxt;
   logic              wb_req;     // pending request flag
   logic [WB_AW-1:0]  adr_q;
   logic              we_q;
   logic [WB_DW-1:0]  wdat_q;
   logic [WB_SW-1:0]  sel_q;
   wb_region_e        region;
   logic              req_none;   // unmapped access pending
   logic              none_err;   // own error pulse for region 11
   logic              resp_ack;   // any response this cycle
   logic              resp_err;

   // ------------------------------
   // request register
   // ------------------------------
   assign stb_q   = wbm_cyc_i & wbm_stb_i;
   assign req_nxt = stb_q && !wbm_ack_o && !resp_ack;  // hold off while acking

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         wb_req <= 1'b0;
      else
         wb_req <= req_nxt;
   end

   // payload, master holds it stable for the whole access
   always_ff @(posedge wbm_clk_i)
   begin
      if (req_nxt)
      begin
         adr_q  <= wbm_adr_i;
         we_q   <= wbm_we_i;
         wdat_q <= wbm_dat_i;
         sel_q  <= wbm_sel_i;
      end
   end

   // ------------------------------
   // region decode
   // ------------------------------
   assign region         = wb_region_e'(adr_q[19:18]);
   assign req.req_local  = wb_req && (region == REGION_LOCAL);
   assign req.req_remote = wb_req && ((region == REGION_REMOTE0) ||
                                      (region == REGION_REMOTE1));
   assign req_none       = wb_req && (region == REGION_NONE);

   assign req.adr     = adr_q;
   assign req.we      = we_q;
   assign req.wdat    = wdat_q;
   assign req.sel     = sel_q;
   assign req.reg_idx = reg_idx_e'(adr_q[3:2]);  // word index in the bank

   // ------------------------------
   // response merge and output register
   // ------------------------------
   assign resp_ack = reg_ack_i | br_ack_i | br_err_i | none_err;  // ack rides with err
   assign resp_err = br_err_i | none_err;

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         none_err  <= 1'b0;
         wbm_ack_o <= 1'b0;
         wbm_err_o <= 1'b0;
         wbm_dat_o <= '0;
      end
      else
      begin
         none_err  <= req_none && !none_err;  // single pulse per request
         wbm_ack_o <= resp_ack;
         wbm_err_o <= resp_err;
         if (reg_ack_i)
            wbm_dat_o <= reg_rdata_i;
         else if (br_ack_i)
            wbm_dat_o <= br_rdata_i;  // else keep last read data
      end
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the wb_host testbench with verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_wb_host \
   -f sim.f -o tb_wb_host
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_wb_host > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
   exit 1
fi
exit 0

// File: sim.f
logic/wb_host_pkg.sv
logic/wb_req_if.sv
logic/wb_req_stage.sv
logic/wb_host_regs.sv
logic/wb_bank_bridge.sv
logic/wb_host.sv
testbench/wb_host_checker.sv
testbench/tb_wb_host.sv

// File: testbench/tb_wb_host.sv
`timescale 1ns/1ps

module tb_wb_host;

   localparam logic [15:0] BANK_RST    = 16'h1000;
   localparam logic [31:0] SLV_KEY     = 32'hA5C3_0F69;  // slave read data key
   localparam logic [3:0]  ERR_NIB     = 4'hE;           // slave adr 11:8 that errors
   localparam int          N_RANDOM    = 40;
   localparam int          N_ACCESS    = 21 + N_RANDOM;  // accesses over all tests
   localparam int          TIMEOUT_CYC = 60 * N_ACCESS + 100;

   logic        wbm_clk_i, wbm_rst_n;
   logic        wbm_cyc_i, wbm_stb_i, wbm_we_i;
   logic [31:0] wbm_adr_i, wbm_dat_i, wbm_dat_o;
   logic [3:0]  wbm_sel_i, wbs_sel_o;
   logic        wbm_ack_o, wbm_err_o;
   logic [31:0] wbs_dat_i, wbs_adr_o, wbs_dat_o;
   logic        wbs_ack_i, wbs_err_i, wbs_cyc_o, wbs_stb_o, wbs_we_o;
   logic        wbd_int_rst_n_o, bist_rst_n_o, mac_rst_n_o;
   logic [31:0] cfg_clk_ctrl1_o, cfg_clk_ctrl2_o;
   int          cycle_cnt;

   wb_host #(.BANK_SEL_RST(BANK_RST)) u_wb_host (.*);

   wb_host_checker #(.BANK_RST(BANK_RST), .SLV_KEY(SLV_KEY), .ERR_NIB(ERR_NIB)) u_checker (
      .*,
      .rst_ctrl_o ({mac_rst_n_o, bist_rst_n_o, wbd_int_rst_n_o})
   );

   initial
   begin
      wbm_clk_i = 1'b0;
      forever #50 wbm_clk_i = ~wbm_clk_i;  // 100 ns period
   end

   // ------------------------------
   // master side
   // ------------------------------
   task automatic run_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
      logic got_resp;
      @(posedge wbm_clk_i);
      #10;
      wbm_cyc_i = 1'b1;
      wbm_stb_i = 1'b1;
      wbm_we_i  = we;
      wbm_adr_i = adr;
      wbm_dat_i = dat;
      wbm_sel_i = sel;
      got_resp  = 1'b0;
      while (!got_resp)
      begin
         @(posedge wbm_clk_i);
         #10;
         got_resp = wbm_ack_o | wbm_err_o;  // strobe held until answered
      end
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
      @(posedge wbm_clk_i);  // checker sees the response first
   endtask

   task automatic write_word(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
      run_access(1'b1, adr, dat, sel);
   endtask

   task automatic read_word(input logic [31:0] adr);
      run_access(1'b0, adr, 32'h0, 4'hF);
   endtask

   // ------------------------------
   // slave responder, 1 to 4 cycles
   // ------------------------------
   initial
   begin
      int latency;
      wbs_ack_i = 1'b0;
      wbs_err_i = 1'b0;
      wbs_dat_i = '0;
      forever
      begin
         @(posedge wbm_clk_i);
         #10;
         if (wbs_cyc_o && wbs_stb_o)
         begin
            latency = $urandom_range(1, 4);
            repeat (latency - 1)
            begin
               @(posedge wbm_clk_i);
               #10;
            end
            if (wbs_adr_o[11:8] == ERR_NIB)
               wbs_err_i = 1'b1;  // error window
            else
            begin
               wbs_ack_i = 1'b1;
               wbs_dat_i = wbs_adr_o ^ SLV_KEY;
            end
            @(posedge wbm_clk_i);
            #10;
            wbs_ack_i = 1'b0;
            wbs_err_i = 1'b0;
         end
      end
   end

   // ------------------------------
   // test sequence
   // ------------------------------
   initial
   begin
      logic [31:0] rnd_a, rnd_d, rnd_c;
      void'($urandom(32'h6df12821));
      wbm_rst_n = 1'b0;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
      wbm_adr_i = '0;
      wbm_dat_i = '0;
      wbm_sel_i = '0;
      repeat (8) @(posedge wbm_clk_i);
      #10 wbm_rst_n = 1'b1;

      u_checker.begin_test("reset_values");
      read_word(32'h0008_0004);  // bank select
      read_word(32'h0008_0000);  // global control
      u_checker.end_test();

      u_checker.begin_test("local_regs");
      write_word(32'h0008_0000, 32'h1234_5607, 4'b0101);  // partial sel
      read_word(32'h0008_0000);
      write_word(32'h0008_0000, 32'hFFFF_FF05, 4'b0001);
      read_word(32'h0008_0000);
      write_word(32'h0008_0008, 32'hDEAD_BEEF, 4'b0000);  // whole word anyway
      write_word(32'h0008_000C, 32'h0BAD_F00D, 4'b1000);
      read_word(32'h0008_0008);
      read_word(32'h0008_000C);
      u_checker.end_test();

      u_checker.begin_test("remote_access");
      write_word(32'h0008_0004, 32'hFFFF_ABCD, 4'hF);
      read_word(32'h0008_0004);
      write_word(32'h0001_2344, 32'h55AA_1234, 4'b0110);
      read_word(32'h0000_0F10);
      read_word(32'h0004_5678);  // region 01
      u_checker.end_test();

      u_checker.begin_test("remote_error");
      read_word(32'h0000_0E00);
      write_word(32'h0004_1E04, 32'h0123_4567, 4'hF);
      read_word(32'h0008_0004);
      read_word(32'h0008_0000);
      u_checker.end_test();

      u_checker.begin_test("unmapped");
      read_word(32'h000C_0000);
      write_word(32'h000C_0008, 32'hCAFE_0001, 4'hF);
      u_checker.end_test();

      u_checker.begin_test("random_mix");
      for (int i = 0; i < N_RANDOM; i++)
      begin
         rnd_a = $urandom;
         rnd_d = $urandom;
         rnd_c = $urandom;  // region, we, sel
         run_access(rnd_c[2], {rnd_a[31:20], rnd_c[1:0], rnd_a[17:0]}, rnd_d, rnd_c[7:4]);
      end
      u_checker.end_test();

      u_checker.print_counts();
      if (u_checker.error_count == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // run limit from the access count
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYC)
      begin
         @(posedge wbm_clk_i);
         cycle_cnt++;
      end
      $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: testbench/wb_host_checker.sv
`timescale 1ns/1ps

module wb_host_checker #(
   parameter logic [15:0] BANK_RST = 16'h1000,
   parameter logic [31:0] SLV_KEY  = 32'hA5C3_0F69,
   parameter logic [3:0]  ERR_NIB  = 4'hE
) (
   input logic        wbm_clk_i,
   input logic        wbm_rst_n,
   input logic        wbm_cyc_i,
   input logic        wbm_stb_i,
   input logic        wbm_we_i,
   input logic [31:0] wbm_adr_i,
   input logic [31:0] wbm_dat_i,
   input logic [3:0]  wbm_sel_i,
   input logic [31:0] wbm_dat_o,
   input logic        wbm_ack_o,
   input logic        wbm_err_o,
   input logic        wbs_cyc_o,
   input logic        wbs_stb_o,
   input logic [31:0] wbs_adr_o,
   input logic        wbs_we_o,
   input logic [31:0] wbs_dat_o,
   input logic [3:0]  wbs_sel_o,
   input logic [2:0]  rst_ctrl_o,       // {mac, bist, wbd_int}
   input logic [31:0] cfg_clk_ctrl1_o,
   input logic [31:0] cfg_clk_ctrl2_o
);

   string        test_name;
   int           test_errs = 0;      // errors in the running test
   int           tests_run = 0, tests_failing = 0, error_count = 0, check_count = 0;
   int           lat;                // cycles since the strobe was seen
   logic         busy, slave_seen, cap_we;
   logic [31:0]  cap_adr, cap_dat;
   logic [3:0]   cap_sel;
   logic [31:0]  shadow [0:3];       // glb ctrl, bank sel, clk ctrl 1, clk ctrl 2
   logic [32:0]  ref_val;            // {err, data}

   // bank select 15:2 over adr 17:0
   function automatic logic [31:0] remote_addr(input logic [31:0] adr);
      return {shadow[1][15:2], adr[17:0]};
   endfunction

   // expected {err, data} with read data or the new register value on a local write
   function automatic logic [32:0] ref_resp(input logic we, input logic [31:0] adr,
                                            input logic [31:0] wdat, input logic [3:0] sel);
      logic [31:0] val;
      logic [32:0] res;
      val = shadow[adr[3:2]];
      case (adr[19:18])
         2'b11: res = {1'b1, 32'h0};  // unmapped
         2'b10:
         begin
            if (we && adr[3:2] == 2'd0)
            begin
               for (int b = 0; b < 4; b++)
                  if (sel[b])
                     val[8*b +: 8] = wdat[8*b +: 8];  // per byte lane
            end
            else if (we && adr[3:2] == 2'd1)
               val = {16'h0, wdat[15:0]};  // upper half reads zero
            else if (we)
               val = wdat;                 // clk ctrl ignores sel
            res = {1'b0, val};
         end
         default:
         begin
            val = remote_addr(adr);
            res = {val[11:8] == ERR_NIB, val ^ SLV_KEY};  // slave rule
         end
      endcase
      return res;
   endfunction

   task automatic compare_value(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
      check_count++;
      if (exp_v !== act_v)
      begin
         $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp_v, act_v);
         test_errs++;
         error_count++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("ERROR in %s: %s", test_name, msg);
      test_errs++;
      error_count++;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errs != 0)
         tests_failing++;
      $display("test %s: %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "fail", test_errs);
   endtask

   task automatic print_counts();
      $display("tests %0d, failing %0d, checks %0d, errors %0d",
               tests_run, tests_failing, check_count, error_count);
   endtask

   // ------------------------------
   // watch the ports at mid cycle
   // ------------------------------
   always @(negedge wbm_clk_i)
   begin
      if (!wbm_rst_n)
      begin
         shadow[0] = '0;
         shadow[1] = {16'h0, BANK_RST};
         shadow[2] = '0;
         shadow[3] = '0;
         busy      = 1'b0;
      end
      else if (!busy && wbm_cyc_i && wbm_stb_i)
      begin
         busy       = 1'b1;  // new access
         slave_seen = 1'b0;
         lat        = 0;
         cap_we     = wbm_we_i;
         cap_adr    = wbm_adr_i;
         cap_dat    = wbm_dat_i;
         cap_sel    = wbm_sel_i;
      end
      else if (busy)
      begin
         lat++;
         if (wbs_cyc_o && !slave_seen)
         begin
            slave_seen = 1'b1;
            if (cap_adr[19])
               report_failure("slave cycle started for a local or unmapped access");
            else
            begin
               compare_value("wbs_stb", 32'h1, {31'h0, wbs_stb_o});
               compare_value("wbs_adr", remote_addr(cap_adr), wbs_adr_o);
               compare_value("wbs_dat", cap_dat, wbs_dat_o);
               compare_value("wbs_sel", {28'h0, cap_sel}, {28'h0, wbs_sel_o});
               compare_value("wbs_we", {31'h0, cap_we}, {31'h0, wbs_we_o});
            end
         end
         if (wbm_ack_o)
         begin
            busy    = 1'b0;
            ref_val = ref_resp(cap_we, cap_adr, cap_dat, cap_sel);
            if (!cap_adr[19] && !slave_seen)
               report_failure("remote access answered without a slave cycle");
            if (cap_adr[19] && lat != 3)
               report_failure($sformatf("response came after %0d cycles, not 3", lat));
            compare_value("err", {31'h0, ref_val[32]}, {31'h0, wbm_err_o});
            if (cap_adr[19:18] == 2'b10 && cap_we)
               shadow[cap_adr[3:2]] = ref_val[31:0];  // local write lands
            else if (!cap_we && !ref_val[32])
               compare_value("rdata", ref_val[31:0], wbm_dat_o);
            compare_value("rst_ctrl", {29'h0, shadow[0][2:0]}, {29'h0, rst_ctrl_o});
            compare_value("clk_ctrl1", shadow[2], cfg_clk_ctrl1_o);
            compare_value("clk_ctrl2", shadow[3], cfg_clk_ctrl2_o);
         end
         else if (wbm_err_o)
            report_failure("wbm_err_o raised without wbm_ack_o");
      end
   end

endmodule
